// File: include/sb_config.svh
`ifndef SB_CONFIG_SVH
`define SB_CONFIG_SVH

// store queue entries
`define SB_DEPTH 4

// data memory size in words, byte address bits 7:2 pick the word
`define SB_RAM_WORDS 64

// cycle limit for testbench wait loops
`define SB_TIMEOUT 200

`endif

// File: source/data_ram.sv
`timescale 1ns/100ps
`include "sb_config.svh"

module data_ram (
    input  logic           clk,
    input  logic           rst,

    // request, one cycle when either mask is set
    input  sb_pkg::addr_t  addr,
    input  sb_pkg::mask_t  rmask,
    input  sb_pkg::mask_t  wmask,
    input  sb_pkg::word_t  wdata,

    // answer one cycle later
    output logic           resp,
    output sb_pkg::word_t  rdata
);

    import sb_pkg::*;

    localparam int IDX_W = $clog2(`SB_RAM_WORDS);

    word_t              mem [`SB_RAM_WORDS];
    logic [IDX_W-1:0]   idx;
    logic               req;

    // word select, low two bits are the byte offset
    assign idx = addr[IDX_W+1:2];
    assign req = (rmask != '0) || (wmask != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SB_RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
            resp  <= 1'b0;
            rdata <= '0;
        end else begin
            resp <= req;
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            // whole word back, the requester picks its bytes
            if (rmask != '0) begin
                rdata <= mem[idx];
            end
        end
    end

endmodule : data_ram

// File: source/load_forward.sv
`timescale 1ns/100ps
`include "sb_config.svh"

module load_forward (
    // pending load from sb_control
    input  sb_pkg::addr_t  load_addr,
    input  sb_pkg::mask_t  load_mask,

    // queue contents
    input  logic           entry_valid [`SB_DEPTH],
    input  sb_pkg::addr_t  entry_addr  [`SB_DEPTH],
    input  sb_pkg::mask_t  entry_mask  [`SB_DEPTH],
    input  sb_pkg::word_t  entry_data  [`SB_DEPTH],

    output logic           fwd_hit,
    output sb_pkg::word_t  fwd_data
);

    import sb_pkg::*;

    logic [`SB_DEPTH-1:0]  match;
    sb_index_t             sel;

    // exact address and mask only, partial overlaps fall through to memory
    always_comb begin
        for (int i = 0; i < `SB_DEPTH; i++) begin
            match[i] = entry_valid[i]
                    && (load_mask != '0)
                    && (entry_addr[i] == load_addr)
                    && (entry_mask[i] == load_mask);
        end
    end

    // later slots are younger, so the last match wins
    always_comb begin
        sel = '0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (match[i]) begin
                sel = sb_index_t'(i);
            end
        end
    end

    assign fwd_hit  = |match;
    assign fwd_data = entry_data[sel];

endmodule : load_forward

// File: source/sb_control.sv
`timescale 1ns/100ps

module sb_control (
    input  logic           clk,
    input  logic           rst,

    // client strobes
    input  sb_pkg::mask_t  store_mask,
    input  sb_pkg::addr_t  load_addr,
    input  sb_pkg::mask_t  load_mask,

    // queue state
    input  logic           empty,
    input  sb_pkg::addr_t  head_addr,
    input  sb_pkg::word_t  head_data,
    input  sb_pkg::mask_t  head_mask,
    input  logic           head_sent,

    // forwarding result for the pending load
    input  logic           fwd_hit,
    input  sb_pkg::word_t  fwd_data,

    // memory response
    input  logic           mem_resp,
    input  sb_pkg::word_t  mem_rdata,

    output sb_pkg::addr_t  pend_addr,
    output sb_pkg::mask_t  pend_mask,
    output logic           pop,
    output logic           mark_sent,

    // memory request
    output sb_pkg::addr_t  mem_addr,
    output sb_pkg::mask_t  mem_rmask,
    output sb_pkg::mask_t  mem_wmask,
    output sb_pkg::word_t  mem_wdata,

    // client responses
    output logic           store_resp,
    output logic           load_resp,
    output sb_pkg::word_t  load_data
);

    import sb_pkg::*;

    logic   rd_out;
    logic   pend_valid;
    logic   issue_wr;
    logic   issue_rd;
    logic   fwd_resp;
    logic   rd_resp;

    assign pend_valid = (pend_mask != '0);

    // stores first, a read only goes out once the queue has drained
    assign issue_wr = !empty && !head_sent;
    assign issue_rd = empty && pend_valid && !rd_out;

    assign mem_addr  = issue_wr ? head_addr : pend_addr;
    assign mem_wmask = issue_wr ? head_mask : '0;
    assign mem_rmask = issue_rd ? pend_mask : '0;
    assign mem_wdata = head_data;

    assign mark_sent = issue_wr;

    // a response belongs to whichever request is outstanding
    assign pop     = mem_resp && head_sent;
    assign rd_resp = mem_resp && rd_out;

    assign fwd_resp  = pend_valid && !rd_out && fwd_hit;
    assign load_resp = fwd_resp || rd_resp;
    assign load_data = rd_out ? mem_rdata : fwd_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_addr  <= '0;
            pend_mask  <= '0;
            rd_out     <= 1'b0;
            store_resp <= 1'b0;
        end else begin
            store_resp <= (store_mask != '0);

            // new load replaces a finished one
            if (load_mask != '0) begin
                pend_addr <= load_addr;
                pend_mask <= load_mask;
            end else if (load_resp) begin
                pend_mask <= '0;
            end

            if (issue_rd) begin
                rd_out <= 1'b1;
            end else if (rd_resp) begin
                rd_out <= 1'b0;
            end
        end
    end

endmodule : sb_control

// File: source/sb_pkg.sv
`include "sb_config.svh"

package sb_pkg;

    // 32-bit data word
    typedef logic [31:0] word_t;

    // byte address, word aligned
    typedef logic [31:0] addr_t;

    // byte enables, all zero means no request
    typedef logic [3:0] mask_t;

    // queue slot, 0 is the oldest store
    typedef logic [$clog2(`SB_DEPTH)-1:0] sb_index_t;

endpackage : sb_pkg

// File: source/store_buffer_top.sv
`timescale 1ns/100ps
`include "sb_config.svh"

module store_buffer_top (
    input  logic           clk,
    input  logic           rst,

    input  sb_pkg::addr_t  store_addr,
    input  sb_pkg::word_t  store_data,
    input  sb_pkg::mask_t  store_mask,

    input  sb_pkg::addr_t  load_addr,
    input  sb_pkg::mask_t  load_mask,

    output logic           full,
    output logic           store_resp,
    output logic           load_resp,
    output sb_pkg::word_t  load_data
);

    import sb_pkg::*;

    // queue to control
    logic   empty;
    addr_t  head_addr;
    word_t  head_data;
    mask_t  head_mask;
    logic   head_sent;
    logic   pop;
    logic   mark_sent;

    // queue to forwarding
    logic   entry_valid [`SB_DEPTH];
    addr_t  entry_addr  [`SB_DEPTH];
    mask_t  entry_mask  [`SB_DEPTH];
    word_t  entry_data  [`SB_DEPTH];

    // pending load and forwarding result
    addr_t  pend_addr;
    mask_t  pend_mask;
    logic   fwd_hit;
    word_t  fwd_data;

    // memory port
    addr_t  mem_addr;
    mask_t  mem_rmask;
    mask_t  mem_wmask;
    word_t  mem_wdata;
    logic   mem_resp;
    word_t  mem_rdata;

    sb_control u_sb_control (
        .clk        (clk),
        .rst        (rst),
        .store_mask (store_mask),
        .load_addr  (load_addr),
        .load_mask  (load_mask),
        .empty      (empty),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .head_mask  (head_mask),
        .head_sent  (head_sent),
        .fwd_hit    (fwd_hit),
        .fwd_data   (fwd_data),
        .mem_resp   (mem_resp),
        .mem_rdata  (mem_rdata),
        .pend_addr  (pend_addr),
        .pend_mask  (pend_mask),
        .pop        (pop),
        .mark_sent  (mark_sent),
        .mem_addr   (mem_addr),
        .mem_rmask  (mem_rmask),
        .mem_wmask  (mem_wmask),
        .mem_wdata  (mem_wdata),
        .store_resp (store_resp),
        .load_resp  (load_resp),
        .load_data  (load_data)
    );

    store_queue u_store_queue (
        .clk         (clk),
        .rst         (rst),
        .push_addr   (store_addr),
        .push_data   (store_data),
        .push_mask   (store_mask),
        .pop         (pop),
        .mark_sent   (mark_sent),
        .empty       (empty),
        .full        (full),
        .head_addr   (head_addr),
        .head_data   (head_data),
        .head_mask   (head_mask),
        .head_sent   (head_sent),
        .entry_valid (entry_valid),
        .entry_addr  (entry_addr),
        .entry_mask  (entry_mask),
        .entry_data  (entry_data)
    );

    load_forward u_load_forward (
        .load_addr   (pend_addr),
        .load_mask   (pend_mask),
        .entry_valid (entry_valid),
        .entry_addr  (entry_addr),
        .entry_mask  (entry_mask),
        .entry_data  (entry_data),
        .fwd_hit     (fwd_hit),
        .fwd_data    (fwd_data)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .rst   (rst),
        .addr  (mem_addr),
        .rmask (mem_rmask),
        .wmask (mem_wmask),
        .wdata (mem_wdata),
        .resp  (mem_resp),
        .rdata (mem_rdata)
    );

endmodule : store_buffer_top

// File: source/store_queue.sv
`timescale 1ns/100ps
`include "sb_config.svh"

module store_queue (
    input  logic           clk,
    input  logic           rst,

    // push side, straight from the store strobe
    input  sb_pkg::addr_t  push_addr,
    input  sb_pkg::word_t  push_data,
    input  sb_pkg::mask_t  push_mask,

    // from sb_control
    input  logic           pop,
    input  logic           mark_sent,

    output logic           empty,
    output logic           full,

    // oldest store
    output sb_pkg::addr_t  head_addr,
    output sb_pkg::word_t  head_data,
    output sb_pkg::mask_t  head_mask,
    output logic           head_sent,

    // all slots, for forwarding
    output logic           entry_valid [`SB_DEPTH],
    output sb_pkg::addr_t  entry_addr  [`SB_DEPTH],
    output sb_pkg::mask_t  entry_mask  [`SB_DEPTH],
    output sb_pkg::word_t  entry_data  [`SB_DEPTH]
);

    import sb_pkg::*;

    localparam int CNT_W = $clog2(`SB_DEPTH) + 1;

    addr_t              q_addr [`SB_DEPTH];
    word_t              q_data [`SB_DEPTH];
    mask_t              q_mask [`SB_DEPTH];
    addr_t              nxt_addr [`SB_DEPTH];
    word_t              nxt_data [`SB_DEPTH];
    mask_t              nxt_mask [`SB_DEPTH];

    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   base;
    logic               push;
    logic               push_ok;
    sb_index_t          wr_idx;

    assign push = (push_mask != '0);

    // occupancy once the pop has shifted everything down
    assign base    = count - CNT_W'(pop);
    assign push_ok = push && (base != CNT_W'(`SB_DEPTH));
    assign wr_idx  = sb_index_t'(base);

    always_comb begin
        nxt_addr = q_addr;
        nxt_data = q_data;
        nxt_mask = q_mask;
        if (pop) begin
            for (int i = 0; i < `SB_DEPTH - 1; i++) begin
                nxt_addr[i] = q_addr[i+1];
                nxt_data[i] = q_data[i+1];
                nxt_mask[i] = q_mask[i+1];
            end
        end
        // new store lands in first free slot after the shift
        if (push_ok) begin
            nxt_addr[wr_idx] = push_addr;
            nxt_data[wr_idx] = push_data;
            nxt_mask[wr_idx] = push_mask;
        end
    end

    always_ff @(posedge clk) begin
        q_addr <= nxt_addr;
        q_data <= nxt_data;
        q_mask <= nxt_mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            head_sent <= 1'b0;
        end else begin
            count <= base + CNT_W'(push_ok);
            // next head has not gone out yet
            if (pop) begin
                head_sent <= 1'b0;
            end else if (mark_sent) begin
                head_sent <= 1'b1;
            end
        end
    end

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(`SB_DEPTH));

    assign head_addr = q_addr[0];
    assign head_data = q_data[0];
    assign head_mask = q_mask[0];

    // entries stay packed toward slot 0
    always_comb begin
        for (int i = 0; i < `SB_DEPTH; i++) begin
            entry_valid[i] = (CNT_W'(i) < count);
            entry_addr[i]  = q_addr[i];
            entry_mask[i]  = q_mask[i];
            entry_data[i]  = q_data[i];
        end
    end

endmodule : store_queue

// File: testbench/sb_checker.sv
`timescale 1ns/100ps

module sb_checker (
    input  logic           clk,
    input  logic           rst,
    input  sb_pkg::mask_t  store_mask,
    input  logic           full,
    input  logic           store_resp,
    input  logic           load_resp,
    input  sb_pkg::word_t  load_data,

    // expected result strobed together with each load
    input  logic           exp_push,
    input  logic           exp_fwd,
    input  sb_pkg::addr_t  exp_addr,
    input  sb_pkg::mask_t  exp_mask,
    input  sb_pkg::word_t  exp_data,

    output int             errors,
    output int             pending
);

    import sb_pkg::*;

    addr_t  q_addr [$];
    mask_t  q_mask [$];
    word_t  q_data [$];
    logic   q_fwd  [$];
    int     q_cyc  [$];
    int     cyc;
    logic   store_prev;
    logic   rst_prev;
    word_t  keep;

    function automatic word_t byte_bits(mask_t m);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = {8{m[b]}};
        end
        return w;
    endfunction

    initial begin
        errors     = 0;
        pending    = 0;
        cyc        = 0;
        store_prev = 1'b0;
        rst_prev   = 1'b0;
    end

    // all outputs are settled by the falling edge
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rst_prev && (full !== 1'b0 || store_resp !== 1'b0 || load_resp !== 1'b0)) begin
            errors++;
            $display("FAILED reset outputs: full %h store_resp %h load_resp %h expected 0",
                     full, store_resp, load_resp);
        end
        if (store_resp !== store_prev) begin
            errors++;
            $display("FAILED store_resp: got %h expected %h at %0t",
                     store_resp, store_prev, $time);
        end
        if (load_resp !== 1'b0) begin
            if (q_data.size() == 0) begin
                errors++;
                $display("load response at %0t with no load outstanding", $time);
            end else begin
                // only the requested bytes are defined
                keep = byte_bits(q_mask[0]);
                if ((load_data & keep) !== (q_data[0] & keep)) begin
                    errors++;
                    $display("FAILED load_data: addr %h mask %h got %h expected %h",
                             q_addr[0], q_mask[0], load_data & keep, q_data[0] & keep);
                end
                if (q_fwd[0] && (cyc - q_cyc[0] != 1)) begin
                    errors++;
                    $display("forwarded load at %h answered after %0d cycles instead of 1",
                             q_addr[0], cyc - q_cyc[0]);
                end
                void'(q_addr.pop_front());
                void'(q_mask.pop_front());
                void'(q_data.pop_front());
                void'(q_fwd.pop_front());
                void'(q_cyc.pop_front());
            end
        end
        if (exp_push) begin
            q_addr.push_back(exp_addr);
            q_mask.push_back(exp_mask);
            q_data.push_back(exp_data);
            q_fwd.push_back(exp_fwd);
            q_cyc.push_back(cyc);
        end
        store_prev = (store_mask != '0);
        rst_prev   = rst;
        pending    = q_data.size();
    end

endmodule : sb_checker

// File: testbench/tb_store_buffer.sv
`timescale 1ns/100ps
`include "sb_config.svh"

module tb_store_buffer;

    import sb_pkg::*;

    logic         clk = 1'b0;
    logic         rst;
    addr_t        store_addr;
    word_t        store_data;
    mask_t        store_mask;
    addr_t        load_addr;
    mask_t        load_mask;
    logic         full;
    logic         store_resp;
    logic         load_resp;
    word_t        load_data;
    logic         exp_push;
    logic         exp_fwd;
    addr_t        exp_addr;
    mask_t        exp_mask;
    word_t        exp_data;
    int           errors;
    int           pending;
    int           tb_errors = 0;
    logic         full_seen = 1'b0;
    logic [7:0]   model [256];
    addr_t        written [$];
    addr_t        recent [$];
    addr_t        last_addr;
    mask_t        last_mask;

    always #50 clk = ~clk;

    store_buffer_top u_store_buffer_top (.*);

    sb_checker u_sb_checker (.*);

    function automatic mask_t pick_mask();
        case ($urandom % 7)
            0: return 4'hf;
            1: return 4'h3;
            2: return 4'hc;
            3: return 4'h1;
            4: return 4'h2;
            5: return 4'h4;
            default: return 4'h8;
        endcase
    endfunction

    function automatic addr_t pick_addr();
        return addr_t'(($urandom % 64) * 4);
    endfunction

    // the queue only ever holds some of the last four stores
    function automatic logic in_recent(addr_t a);
        foreach (recent[i]) begin
            if (recent[i] == a) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
        store_mask = '0;
        load_mask  = '0;
        exp_push   = 1'b0;
        exp_fwd    = 1'b0;
    endtask

    task automatic put_store(addr_t a, word_t d, mask_t m);
        int n = 0;
        while (full && n < `SB_TIMEOUT) begin
            full_seen = 1'b1;
            step();
            n++;
        end
        if (full) begin
            tb_errors++;
            $display("timeout: full stayed high for %0d cycles", n);
        end
        store_addr = a;
        store_data = d;
        store_mask = m;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                model[int'(a[7:0]) + b] = d[8*b +: 8];
            end
        end
        written.push_back(a);
        recent.push_back(a);
        if (recent.size() > `SB_DEPTH) begin
            void'(recent.pop_front());
        end
        last_addr = a;
        last_mask = m;
    endtask

    task automatic put_load(addr_t a, mask_t m, logic fwd);
        word_t w = '0;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                w[8*b +: 8] = model[int'(a[7:0]) + b];
            end
        end
        load_addr = a;
        load_mask = m;
        exp_addr  = a;
        exp_mask  = m;
        exp_data  = w;
        exp_fwd   = fwd;
        exp_push  = 1'b1;
    endtask

    task automatic wait_load();
        int   n = 0;
        logic got = 1'b0;
        step();
        while (!got && n < `SB_TIMEOUT) begin
            @(negedge clk);
            got = (load_resp === 1'b1);
            n++;
        end
        if (!got) begin
            tb_errors++;
            $display("timeout: load at %h got no response in %0d cycles", exp_addr, n);
        end
        step();
    endtask

    initial begin
        addr_t la;
        mask_t lm;
        void'($urandom(93205));
        rst        = 1'b1;
        store_addr = '0;
        store_data = '0;
        store_mask = '0;
        load_addr  = '0;
        load_mask  = '0;
        exp_push   = 1'b0;
        exp_fwd    = 1'b0;
        exp_addr   = '0;
        exp_mask   = '0;
        exp_data   = '0;
        foreach (model[i]) begin
            model[i] = 8'h00;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // cleared memory right after reset
        repeat (4) begin
            put_load(pick_addr(), 4'hf, 1'b0);
            wait_load();
        end

        // two stores to one word where the younger one must win
        put_store(32'h40, 32'h1111_1111, 4'hf);
        step();
        put_store(32'h40, 32'h2222_2222, 4'hf);
        put_load(32'h40, 4'hf, 1'b1);
        wait_load();
        put_store(32'h80, 32'h3344_5566, 4'h3);
        step();
        put_load(32'h80, 4'h3, 1'b1);
        wait_load();

        // partial overlaps wait for the drain
        put_store(32'hc0, 32'haabb_ccdd, 4'hf);
        step();
        put_load(32'hc0, 4'h3, 1'b0);
        wait_load();
        put_store(32'hc4, 32'h0102_0304, 4'h4);
        step();
        put_load(32'hc4, 4'hf, 1'b0);
        wait_load();

        // back-to-back burst to distinct words and a read of each
        written.delete();
        for (int i = 0; i < 10; i++) begin
            put_store(addr_t'(32'h20 + 4 * i), $urandom, pick_mask());
            step();
        end
        if (!full_seen) begin
            tb_errors++;
            $display("full never went high during the store burst");
        end
        foreach (written[i]) begin
            put_load(written[i], 4'hf, 1'b0);
            wait_load();
        end

        // random mix where loads either hit the youngest store or miss the queue
        repeat (400) begin
            la = pick_addr();
            lm = pick_mask();
            case ($urandom % 4)
                0: begin
                    put_store(la, $urandom, lm);
                    step();
                end
                1, 2: begin
                    if ($urandom % 2 == 0) begin
                        put_store(pick_addr(), $urandom, pick_mask());
                    end
                    if (($urandom % 2 == 0) || in_recent(la)) begin
                        la = last_addr;
                        lm = last_mask;
                    end
                    put_load(la, lm, 1'b0);
                    wait_load();
                end
                default: step();
            endcase
        end
        repeat (4) step();

        $display("errors: checker %0d, testbench %0d, loads without response %0d",
                 errors, tb_errors, pending);
        if (errors == 0 && tb_errors == 0 && pending == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_store_buffer

// File: verilog.f
+incdir+include
source/sb_pkg.sv
source/store_queue.sv
source/load_forward.sv
source/sb_control.sv
source/data_ram.sv
source/store_buffer_top.sv
testbench/sb_checker.sv
testbench/tb_store_buffer.sv
